// ==== include/mini_cpu_defines.svh ====
`ifndef MINI_CPU_DEFINES_SVH
`define MINI_CPU_DEFINES_SVH

// fetch starts one word below the boot address
`define MINI_CPU_RESET_PC 32'h1bff_fffc

`define MINI_CPU_NUM_REGS 32

// 3R-type, opcode in inst[31:15]
`define MINI_CPU_OP_ADD_W 17'h00020
`define MINI_CPU_OP_SUB_W 17'h00022

// 2RI12-type, opcode in inst[31:22]
`define MINI_CPU_OP_ADDI_W 10'h00a

// 1RI20-type, opcode in inst[31:25]
`define MINI_CPU_OP_LU12I_W 7'h0a

// branches, opcode in inst[31:26]
`define MINI_CPU_OP_B   6'h14
`define MINI_CPU_OP_BEQ 6'h16
`define MINI_CPU_OP_BNE 6'h17

`endif

// ==== hw/mini_cpu_pkg.sv ====
`include "mini_cpu_defines.svh"

package mini_cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // register number sized from the register count
    typedef logic [$clog2(`MINI_CPU_NUM_REGS)-1:0] reg_idx_t;

    // how writeback combines src1 and src2
    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_lui = 2'd2
    } alu_op_t;

    // fetched word and the address it came from
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } if_to_id_t;

    // operands already resolved, incl. forwarding
    typedef struct packed {
        pc_t      pc;
        alu_op_t  alu_op;
        word_t    src1;
        word_t    src2;
        reg_idx_t dest;
        logic     gr_we;
    } id_to_wb_t;

    // one entry per retired instruction
    typedef struct packed {
        pc_t      pc;
        logic     rf_we;
        reg_idx_t rf_wnum;
        word_t    rf_wdata;
    } wb_trace_t;

endpackage

// ==== hw/if_stage.sv ====
`timescale 1ns/1ns
`include "mini_cpu_defines.svh"

module if_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    id_allowin,
    input  logic                    br_taken,
    input  mini_cpu_pkg::pc_t       br_target,
    output logic                    inst_sram_en,
    output mini_cpu_pkg::pc_t       inst_sram_addr,
    input  mini_cpu_pkg::inst_t     inst_sram_rdata,
    output logic                    if_to_id_valid,
    output mini_cpu_pkg::if_to_id_t if_to_id
);

    logic              if_valid;
    logic              if_allowin;
    mini_cpu_pkg::pc_t if_pc;
    mini_cpu_pkg::pc_t seq_pc;
    mini_cpu_pkg::pc_t next_pc;

    // fetch never waits on the SRAM, only on decode
    assign if_allowin = ~if_valid | id_allowin;

    assign seq_pc  = if_pc + 32'd4;
    assign next_pc = br_taken ? br_target : seq_pc;

    // request goes out in the cycle the PC is chosen
    assign inst_sram_en   = if_allowin;
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
            if_pc    <= `MINI_CPU_RESET_PC;
        end else if (if_allowin) begin
            if_valid <= 1'b1;
            if_pc    <= next_pc;
        end
    end

    // read data arrives one cycle after the request, aligned with if_pc
    assign if_to_id_valid = if_valid;
    assign if_to_id.pc    = if_pc;
    assign if_to_id.inst  = inst_sram_rdata;

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ns
`include "mini_cpu_defines.svh"

module id_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    if_to_id_valid,
    input  mini_cpu_pkg::if_to_id_t if_to_id,
    output logic                    id_allowin,
    output logic                    br_taken,
    output mini_cpu_pkg::pc_t       br_target,
    output mini_cpu_pkg::reg_idx_t  rf_raddr1,
    output mini_cpu_pkg::reg_idx_t  rf_raddr2,
    input  mini_cpu_pkg::word_t     rf_rdata1,
    input  mini_cpu_pkg::word_t     rf_rdata2,
    input  logic                    wb_fwd_we,
    input  mini_cpu_pkg::reg_idx_t  wb_fwd_dest,
    input  mini_cpu_pkg::word_t     wb_fwd_data,
    input  logic                    wb_allowin,
    output logic                    id_to_wb_valid,
    output mini_cpu_pkg::id_to_wb_t id_to_wb
);

    logic                   id_valid;
    mini_cpu_pkg::pc_t      id_pc;
    mini_cpu_pkg::inst_t    id_inst;
    mini_cpu_pkg::reg_idx_t rd;
    mini_cpu_pkg::reg_idx_t rj;
    mini_cpu_pkg::reg_idx_t rk;
    logic                   inst_add_w;
    logic                   inst_sub_w;
    logic                   inst_addi_w;
    logic                   inst_lu12i_w;
    logic                   inst_beq;
    logic                   inst_bne;
    logic                   inst_b;
    mini_cpu_pkg::word_t    imm_si12;
    mini_cpu_pkg::word_t    imm_lui;
    mini_cpu_pkg::word_t    offs16;
    mini_cpu_pkg::word_t    offs26;
    mini_cpu_pkg::word_t    src1_val;
    mini_cpu_pkg::word_t    src2_val;
    logic                   rs_equal;

    // decode finishes in one cycle
    assign id_allowin     = ~id_valid | wb_allowin;
    assign id_to_wb_valid = id_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            // fall-through word behind a taken branch is squashed here
            id_valid <= if_to_id_valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_pc   <= if_to_id.pc;
            id_inst <= if_to_id.inst;
        end
    end

    // register fields
    assign rd = id_inst[4:0];
    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    // opcode match
    assign inst_add_w   = (id_inst[31:15] == `MINI_CPU_OP_ADD_W);
    assign inst_sub_w   = (id_inst[31:15] == `MINI_CPU_OP_SUB_W);
    assign inst_addi_w  = (id_inst[31:22] == `MINI_CPU_OP_ADDI_W);
    assign inst_lu12i_w = (id_inst[31:25] == `MINI_CPU_OP_LU12I_W);
    assign inst_beq     = (id_inst[31:26] == `MINI_CPU_OP_BEQ);
    assign inst_bne     = (id_inst[31:26] == `MINI_CPU_OP_BNE);
    assign inst_b       = (id_inst[31:26] == `MINI_CPU_OP_B);

    // immediates
    assign imm_si12 = {{20{id_inst[21]}}, id_inst[21:10]};
    assign imm_lui  = {id_inst[24:5], 12'b0};
    assign offs16   = {{14{id_inst[25]}}, id_inst[25:10], 2'b00};
    assign offs26   = {{4{id_inst[9]}}, id_inst[9:0], id_inst[25:10], 2'b00};

    // branches compare rj against rd, 3R ops read rk
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_add_w || inst_sub_w) ? rk : rd;

    // writeback bypass, r0 excluded
    assign src1_val = (wb_fwd_we && wb_fwd_dest != '0 && wb_fwd_dest == rf_raddr1) ?
                      wb_fwd_data : rf_rdata1;
    assign src2_val = (wb_fwd_we && wb_fwd_dest != '0 && wb_fwd_dest == rf_raddr2) ?
                      wb_fwd_data : rf_rdata2;

    assign rs_equal = (src1_val == src2_val);

    assign br_taken  = id_valid & (inst_b | (inst_beq & rs_equal) | (inst_bne & ~rs_equal));
    assign br_target = id_pc + (inst_b ? offs26 : offs16);

    always_comb begin
        id_to_wb.pc     = id_pc;
        id_to_wb.alu_op = mini_cpu_pkg::alu_add;
        id_to_wb.src1   = src1_val;
        id_to_wb.src2   = src2_val;
        id_to_wb.dest   = rd;
        // branches and unknown encodings retire without a write
        id_to_wb.gr_we  = 1'b0;
        if (inst_add_w) begin
            id_to_wb.gr_we = 1'b1;
        end else if (inst_sub_w) begin
            id_to_wb.alu_op = mini_cpu_pkg::alu_sub;
            id_to_wb.gr_we  = 1'b1;
        end else if (inst_addi_w) begin
            id_to_wb.src2  = imm_si12;
            id_to_wb.gr_we = 1'b1;
        end else if (inst_lu12i_w) begin
            id_to_wb.alu_op = mini_cpu_pkg::alu_lui;
            id_to_wb.src2   = imm_lui;
            id_to_wb.gr_we  = 1'b1;
        end
    end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ns
`include "mini_cpu_defines.svh"

module regfile (
    input  logic                   clk,
    input  mini_cpu_pkg::reg_idx_t raddr1,
    input  mini_cpu_pkg::reg_idx_t raddr2,
    output mini_cpu_pkg::word_t    rdata1,
    output mini_cpu_pkg::word_t    rdata2,
    input  logic                   we,
    input  mini_cpu_pkg::reg_idx_t waddr,
    input  mini_cpu_pkg::word_t    wdata
);

    mini_cpu_pkg::word_t regs [`MINI_CPU_NUM_REGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read, r0 hard-wired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/wb_stage.sv ====
`timescale 1ns/1ns

module wb_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    id_to_wb_valid,
    input  mini_cpu_pkg::id_to_wb_t id_to_wb,
    output logic                    wb_allowin,
    output logic                    rf_we,
    output mini_cpu_pkg::reg_idx_t  rf_waddr,
    output mini_cpu_pkg::word_t     rf_wdata,
    output logic                    wb_fwd_we,
    output mini_cpu_pkg::reg_idx_t  wb_fwd_dest,
    output mini_cpu_pkg::word_t     wb_fwd_data,
    output logic                    debug_wb_valid,
    output mini_cpu_pkg::wb_trace_t debug_wb
);

    logic                    wb_valid;
    mini_cpu_pkg::id_to_wb_t wb_bundle;
    mini_cpu_pkg::word_t     wb_result;
    logic                    wb_we;

    // single-cycle stage, nothing can hold it
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= id_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_wb_valid && wb_allowin) begin
            wb_bundle <= id_to_wb;
        end
    end

    always_comb begin
        unique case (wb_bundle.alu_op)
            mini_cpu_pkg::alu_sub: wb_result = wb_bundle.src1 - wb_bundle.src2;
            // upper immediate is already shifted in decode
            mini_cpu_pkg::alu_lui: wb_result = wb_bundle.src2;
            default:               wb_result = wb_bundle.src1 + wb_bundle.src2;
        endcase
    end

    assign wb_we = wb_valid & wb_bundle.gr_we;

    // register file write
    assign rf_we    = wb_we;
    assign rf_waddr = wb_bundle.dest;
    assign rf_wdata = wb_result;

    // same value bypassed to decode
    assign wb_fwd_we   = wb_we;
    assign wb_fwd_dest = wb_bundle.dest;
    assign wb_fwd_data = wb_result;

    // trace
    assign debug_wb_valid    = wb_valid;
    assign debug_wb.pc       = wb_bundle.pc;
    assign debug_wb.rf_we    = wb_we;
    assign debug_wb.rf_wnum  = wb_bundle.dest;
    assign debug_wb.rf_wdata = wb_result;

endmodule

// ==== hw/mini_cpu_top.sv ====
`timescale 1ns/1ns

module mini_cpu_top (
    input  logic                    clk,
    input  logic                    resetn,
    output logic                    inst_sram_en,
    output mini_cpu_pkg::pc_t       inst_sram_addr,
    input  mini_cpu_pkg::inst_t     inst_sram_rdata,
    output logic                    debug_wb_valid,
    output mini_cpu_pkg::wb_trace_t debug_wb
);

    // fetch / decode
    logic                    if_to_id_valid;
    mini_cpu_pkg::if_to_id_t if_to_id;
    logic                    id_allowin;
    logic                    br_taken;
    mini_cpu_pkg::pc_t       br_target;

    // decode / writeback
    logic                    id_to_wb_valid;
    mini_cpu_pkg::id_to_wb_t id_to_wb;
    logic                    wb_allowin;
    logic                    wb_fwd_we;
    mini_cpu_pkg::reg_idx_t  wb_fwd_dest;
    mini_cpu_pkg::word_t     wb_fwd_data;

    // register file
    mini_cpu_pkg::reg_idx_t  rf_raddr1;
    mini_cpu_pkg::reg_idx_t  rf_raddr2;
    mini_cpu_pkg::word_t     rf_rdata1;
    mini_cpu_pkg::word_t     rf_rdata2;
    logic                    rf_we;
    mini_cpu_pkg::reg_idx_t  rf_waddr;
    mini_cpu_pkg::word_t     rf_wdata;

    if_stage u_if_stage (
        .clk             (clk),
        .resetn          (resetn),
        .id_allowin      (id_allowin),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id        (if_to_id)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .resetn         (resetn),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id),
        .id_allowin     (id_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .wb_fwd_we      (wb_fwd_we),
        .wb_fwd_dest    (wb_fwd_dest),
        .wb_fwd_data    (wb_fwd_data),
        .wb_allowin     (wb_allowin),
        .id_to_wb_valid (id_to_wb_valid),
        .id_to_wb       (id_to_wb)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .resetn         (resetn),
        .id_to_wb_valid (id_to_wb_valid),
        .id_to_wb       (id_to_wb),
        .wb_allowin     (wb_allowin),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .wb_fwd_we      (wb_fwd_we),
        .wb_fwd_dest    (wb_fwd_dest),
        .wb_fwd_data    (wb_fwd_data),
        .debug_wb_valid (debug_wb_valid),
        .debug_wb       (debug_wb)
    );

endmodule

// ==== verif/mini_cpu_props.sv ====
`timescale 1ns/1ns

module mini_cpu_props (
    input logic clk,
    input logic resetn,
    input logic if_to_id_valid,
    input logic br_taken,
    input logic rf_we,
    input logic debug_wb_valid
);

    // nothing retires in the first cycle out of reset
    wb_idle_after_reset: assert property (
        @(posedge clk) $rose(resetn) |-> !debug_wb_valid
    ) else $error("debug_wb_valid high in the first cycle after reset");

    // a redirect needs a valid word behind it
    branch_needs_fetch: assert property (
        @(posedge clk) disable iff (!resetn) br_taken |-> if_to_id_valid
    ) else $error("br_taken high while if_to_id_valid is low");

    // register writes only come from retiring instructions
    write_needs_retire: assert property (
        @(posedge clk) disable iff (!resetn) rf_we |-> debug_wb_valid
    ) else $error("rf_we high without debug_wb_valid");

endmodule

bind mini_cpu_top mini_cpu_props u_mini_cpu_props (
    .clk            (clk),
    .resetn         (resetn),
    .if_to_id_valid (if_to_id_valid),
    .br_taken       (br_taken),
    .rf_we          (rf_we),
    .debug_wb_valid (debug_wb_valid)
);

// ==== verif/tb_mini_cpu.sv ====
`timescale 1ns/1ns
`include "mini_cpu_defines.svh"

module tb_mini_cpu;

    localparam logic [31:0] boot_pc    = 32'h1c00_0000;
    localparam int          wait_limit = 2000;

    logic                    clk;
    logic                    resetn;
    logic                    inst_sram_en;
    mini_cpu_pkg::pc_t       inst_sram_addr;
    mini_cpu_pkg::inst_t     inst_sram_rdata;
    logic                    debug_wb_valid;
    mini_cpu_pkg::wb_trace_t debug_wb;

    mini_cpu_pkg::inst_t     prog [256];
    mini_cpu_pkg::inst_t     fetch_word;
    mini_cpu_pkg::wb_trace_t exp_q [$];
    int                      exp_total;
    logic [31:0]             lfsr;
    logic                    checking;
    string                   test_name;

    mini_cpu_top u_mini_cpu_top (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .debug_wb_valid  (debug_wb_valid),
        .debug_wb        (debug_wb)
    );

    always #20 clk = ~clk;

    // unknown encoding that still depends on every address bit
    function automatic mini_cpu_pkg::inst_t fill_word(mini_cpu_pkg::pc_t addr);
        logic [31:0] mix;
        mix = addr ^ (addr >> 9);
        return {6'h3f, mix[25:0]};
    endfunction

    function automatic mini_cpu_pkg::inst_t read_mem(mini_cpu_pkg::pc_t addr);
        mini_cpu_pkg::pc_t offs;
        offs = addr - boot_pc;
        if (offs < 32'd1024) begin
            return prog[offs[9:2]];
        end
        return fill_word(addr);
    endfunction

    // SRAM samples the address mid-cycle and drives data after the next edge
    always @(negedge clk) begin
        if (inst_sram_en) begin
            fetch_word = read_mem(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        #2;
        inst_sram_rdata = fetch_word;
    end

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic mini_cpu_pkg::inst_t enc_3r(logic [16:0] op, logic [4:0] rd,
                                                   logic [4:0] rj, logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic mini_cpu_pkg::inst_t enc_addi(logic [11:0] imm, logic [4:0] rd,
                                                     logic [4:0] rj);
        return {`MINI_CPU_OP_ADDI_W, imm, rj, rd};
    endfunction

    function automatic mini_cpu_pkg::inst_t enc_lu12i(logic [19:0] imm, logic [4:0] rd);
        return {`MINI_CPU_OP_LU12I_W, imm, rd};
    endfunction

    // offsets are in words
    function automatic mini_cpu_pkg::inst_t enc_br(logic [5:0] op, logic [15:0] offs,
                                                   logic [4:0] rj, logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic mini_cpu_pkg::inst_t enc_b(logic [25:0] offs);
        return {`MINI_CPU_OP_B, offs[15:0], offs[25:16]};
    endfunction

    // architectural model emitting one trace entry per executed instruction
    function automatic void run_reference();
        mini_cpu_pkg::word_t     regs [32];
        mini_cpu_pkg::pc_t       pc;
        mini_cpu_pkg::pc_t       nxt;
        mini_cpu_pkg::inst_t     ins;
        mini_cpu_pkg::word_t     a;
        mini_cpu_pkg::word_t     b;
        mini_cpu_pkg::wb_trace_t e;
        int                      i;
        logic                    done;
        for (i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        exp_q.delete();
        pc   = boot_pc;
        done = 1'b0;
        i    = 0;
        while (!done && i < 1000) begin
            ins        = read_mem(pc);
            a          = regs[ins[9:5]];
            b          = regs[ins[4:0]];
            e.pc       = pc;
            e.rf_we    = 1'b0;
            e.rf_wnum  = ins[4:0];
            e.rf_wdata = '0;
            nxt        = pc + 32'd4;
            if (ins[31:15] == `MINI_CPU_OP_ADD_W) begin
                e.rf_we    = 1'b1;
                e.rf_wdata = a + regs[ins[14:10]];
            end else if (ins[31:15] == `MINI_CPU_OP_SUB_W) begin
                e.rf_we    = 1'b1;
                e.rf_wdata = a - regs[ins[14:10]];
            end else if (ins[31:22] == `MINI_CPU_OP_ADDI_W) begin
                e.rf_we    = 1'b1;
                e.rf_wdata = a + {{20{ins[21]}}, ins[21:10]};
            end else if (ins[31:25] == `MINI_CPU_OP_LU12I_W) begin
                e.rf_we    = 1'b1;
                e.rf_wdata = {ins[24:5], 12'h000};
            end else if ((ins[31:26] == `MINI_CPU_OP_BEQ && a == b) ||
                         (ins[31:26] == `MINI_CPU_OP_BNE && a != b)) begin
                nxt = pc + {{14{ins[25]}}, ins[25:10], 2'b00};
            end else if (ins[31:26] == `MINI_CPU_OP_B) begin
                nxt = pc + {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
            end
            // r0 stays zero even though the trace shows the write
            if (e.rf_we && e.rf_wnum != 5'd0) begin
                regs[e.rf_wnum] = e.rf_wdata;
            end
            exp_q.push_back(e);
            done = (nxt == pc);
            pc   = nxt;
            i++;
        end
        exp_total = exp_q.size();
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pc(string name, mini_cpu_pkg::pc_t exp, mini_cpu_pkg::pc_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic string trace_str(mini_cpu_pkg::wb_trace_t t);
        return $sformatf("pc %h we %b r%0d %h", t.pc, t.rf_we, t.rf_wnum, t.rf_wdata);
    endfunction

    // wnum and wdata only count when a register is written
    task automatic check_trace(string name, mini_cpu_pkg::wb_trace_t exp,
                               mini_cpu_pkg::wb_trace_t act);
        logic bad;
        bad = (act.pc !== exp.pc) || (act.rf_we !== exp.rf_we);
        if (exp.rf_we) begin
            bad = bad || (act.rf_wnum !== exp.rf_wnum) || (act.rf_wdata !== exp.rf_wdata);
        end
        if (bad) begin
            abort_run($sformatf("MISMATCH %s expected %s actual %s", name,
                                trace_str(exp), trace_str(act)));
        end
    endtask

    always @(negedge clk) begin
        if (checking && debug_wb_valid && exp_q.size() != 0) begin
            check_trace($sformatf("%s entry %0d", test_name, exp_total - exp_q.size()),
                        exp_q[0], debug_wb);
            void'(exp_q.pop_front());
        end
    end

    function automatic void fill_memory();
        int i;
        for (i = 0; i < 256; i++) begin
            prog[i[7:0]] = fill_word(boot_pc + 32'(i * 4));
        end
    endfunction

    task automatic load_directed();
        fill_memory();
        prog[0]  = enc_lu12i(20'h12345, 5'd1);
        prog[1]  = enc_addi(12'h678, 5'd1, 5'd1);
        prog[2]  = enc_addi(12'hfff, 5'd2, 5'd0);
        prog[3]  = enc_3r(`MINI_CPU_OP_ADD_W, 5'd3, 5'd1, 5'd2);
        prog[4]  = enc_3r(`MINI_CPU_OP_SUB_W, 5'd4, 5'd3, 5'd1);
        // write to r0 and read it back right behind
        prog[5]  = enc_3r(`MINI_CPU_OP_ADD_W, 5'd0, 5'd1, 5'd1);
        prog[6]  = enc_3r(`MINI_CPU_OP_ADD_W, 5'd5, 5'd0, 5'd2);
        prog[7]  = enc_br(`MINI_CPU_OP_BEQ, 16'd2, 5'd4, 5'd2);
        prog[8]  = enc_addi(12'h111, 5'd6, 5'd0);
        prog[9]  = enc_br(`MINI_CPU_OP_BNE, 16'd3, 5'd1, 5'd1);
        prog[10] = enc_br(`MINI_CPU_OP_BNE, 16'd2, 5'd1, 5'd2);
        prog[11] = enc_addi(12'h222, 5'd6, 5'd0);
        prog[12] = enc_b(26'd2);
        prog[13] = enc_addi(12'h333, 5'd7, 5'd0);
        prog[14] = enc_3r(`MINI_CPU_OP_SUB_W, 5'd6, 5'd5, 5'd4);
        // r1 and r2 differ here
        prog[15] = enc_br(`MINI_CPU_OP_BEQ, 16'd2, 5'd1, 5'd2);
        prog[16] = enc_b(26'd0);
    endtask

    task automatic load_random();
        logic [31:0] op;
        logic [31:0] rd;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] imm;
        int          i;
        int          k;
        fill_memory();
        // r1..r7 get values first since the register file has no reset
        for (i = 1; i < 8; i++) begin
            imm            = rand_bits(20);
            prog[i[7:0]-1] = enc_lu12i(imm[19:0], i[4:0]);
        end
        for (i = 7; i < 59; i++) begin
            op  = rand_bits(3);
            rd  = rand_bits(3);
            rj  = rand_bits(3);
            rk  = rand_bits(3);
            imm = rand_bits(20);
            k   = 1 + int'(rand_bits(3));
            if (i + k > 59) begin
                k = 59 - i;
            end
            case (op[2:0])
                3'd0: prog[i[7:0]] = enc_3r(`MINI_CPU_OP_ADD_W, rd[4:0], rj[4:0], rk[4:0]);
                3'd1: prog[i[7:0]] = enc_3r(`MINI_CPU_OP_SUB_W, rd[4:0], rj[4:0], rk[4:0]);
                3'd2, 3'd3: prog[i[7:0]] = enc_addi(imm[11:0], rd[4:0], rj[4:0]);
                3'd4: prog[i[7:0]] = enc_lu12i(imm[19:0], rd[4:0]);
                3'd5: prog[i[7:0]] = enc_br(`MINI_CPU_OP_BEQ, k[15:0], rj[4:0], rd[4:0]);
                3'd6: prog[i[7:0]] = enc_br(`MINI_CPU_OP_BNE, k[15:0], rj[4:0], rd[4:0]);
                default: prog[i[7:0]] = enc_b(k[25:0]);
            endcase
        end
        prog[59] = enc_b(26'd0);
    endtask

    task automatic run_program(string name);
        int n;
        test_name = name;
        @(posedge clk);
        #2;
        resetn   = 1'b0;
        checking = 1'b0;
        run_reference();
        repeat (16) @(posedge clk);
        checking = 1'b1;
        #2;
        resetn = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!inst_sram_en && n < wait_limit);
        if (!inst_sram_en) begin
            abort_run($sformatf("%s: no instruction fetch after reset", name));
        end else begin
            check_pc($sformatf("%s first fetch", name), boot_pc, inst_sram_addr);
        end
        n = 0;
        while (exp_q.size() != 0 && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: trace stopped with %0d entries still expected",
                                name, exp_q.size()));
        end
        checking = 1'b0;
    endtask

    initial begin
        int t;
        clk             = 1'b0;
        resetn          = 1'b0;
        inst_sram_rdata = '0;
        fetch_word      = '0;
        checking        = 1'b0;
        exp_total       = 0;
        lfsr            = 32'h5d5be28d;
        load_directed();
        run_program("directed");
        for (t = 1; t <= 3; t++) begin
            load_random();
            run_program($sformatf("random %0d", t));
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== mini_cpu.f ====
+incdir+include
hw/mini_cpu_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/regfile.sv
hw/wb_stage.sv
hw/mini_cpu_top.sv
verif/mini_cpu_props.sv
verif/tb_mini_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; the exit status of the simulation is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mini_cpu \
    -f mini_cpu.f -o tb_mini_cpu &&
./obj_dir/tb_mini_cpu ||
exit 1
